// ==== hdl/multicore_settings.svh ====
`ifndef MULTICORE_SETTINGS_SVH
`define MULTICORE_SETTINGS_SVH

// number of cores that share the instruction memory
`define NUM_CORES 4

// program counter and instruction word widths
`define PC_WIDTH 16
`define INSTR_WIDTH 24

// the memory is addressed by the low bits of a program counter
`define MEM_ADDR_WIDTH 8

// visible core status fields
`define BUS_WIDTH 8
`define CTRL_WIDTH 25

// seven-segment digits on the board
`define NUM_DIGITS 8

`endif

// ==== hdl/multicorePkg.sv ====
`include "multicore_settings.svh"

package multicorePkg;

	// one core's program counter
	typedef logic [`PC_WIDTH-1:0] pcWord_t;

	// one word of the shared program
	typedef logic [`INSTR_WIDTH-1:0] instrWord_t;

	// what a core exposes for observation on the board
	typedef struct packed {
		logic [`BUS_WIDTH-1:0] bus;
		logic [`CTRL_WIDTH-1:0] ctrl;
		logic endp;
		logic zout;
	} coreStatus_t;

	// segments of one digit, g in bit 6 down to a in bit 0, lit when high
	typedef logic [6:0] segDigit_t;

	// one bit per core, set when that core receives the fetched word
	typedef logic [`NUM_CORES-1:0] grantMask_t;

endpackage

// ==== hdl/cycleCounter.sv ====
`include "multicore_settings.svh"

module cycleCounter (
	input logic c1_endop,
	input logic rstN,
	input logic progDone,
	output multicorePkg::pcWord_t countValue,
	output multicorePkg::pcWord_t storeCount
);

	// free-running count of clock cycles since reset
	always_ff @(posedge c1_endop or negedge rstN) begin
		if (!rstN) begin
			countValue <= '0;
		end else begin
			countValue <= countValue + 1'b1;
		end
	end

	// capture the count present before the edge where core 1 finishes
	always_ff @(posedge c1_endop or negedge rstN) begin
		if (!rstN) begin
			storeCount <= '0;
		end else if (progDone) begin
			storeCount <= countValue;
		end
	end

	// the count never skips or stalls once reset has been released for a cycle
	property countAdvances;
		@(posedge c1_endop) disable iff (!rstN)
			$past(rstN) |-> countValue == multicorePkg::pcWord_t'($past(countValue) + 1'b1);
	endproperty

	countAdvancesCheck: assert property (countAdvances)
		else $error("cycle counter did not advance by one");

endmodule

// ==== hdl/instrMemory.sv ====
`include "multicore_settings.svh"

module instrMemory (
	input logic c1_endop,
	input logic rstN,
	input multicorePkg::pcWord_t readPc,
	input logic loadEn,
	input logic [`MEM_ADDR_WIDTH-1:0] loadAddr,
	input multicorePkg::instrWord_t loadData,
	input logic progDone,
	input multicorePkg::pcWord_t countValue,
	output multicorePkg::instrWord_t memWord
);

	localparam int DEPTH = 1 << `MEM_ADDR_WIDTH;

	multicorePkg::instrWord_t mem [0:DEPTH-1];
	logic [`MEM_ADDR_WIDTH-1:0] readAddr;

	// only the low bits of core 1's program counter reach the memory
	assign readAddr = readPc[`MEM_ADDR_WIDTH-1:0];

	// the loader fills the program, and core 1 leaves its cycle count behind when done
	always_ff @(posedge c1_endop) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData;
		end else if (progDone) begin
			mem[readAddr] <= multicorePkg::instrWord_t'(countValue);
		end
	end

	// registered read returns the old word on a same-address write
	always_ff @(posedge c1_endop or negedge rstN) begin
		if (!rstN) begin
			memWord <= '0;
		end else begin
			memWord <= mem[readAddr];
		end
	end

	// the loader and core 1 share the single write port
	writeExclusiveCheck: assert property (
		@(posedge c1_endop) disable iff (!rstN) !(loadEn && progDone))
		else $error("loader write and program-done write in the same cycle");

endmodule

// ==== hdl/fetchBroadcast.sv ====
`include "multicore_settings.svh"

module fetchBroadcast (
	input logic c1_endop,
	input logic rstN,
	input multicorePkg::pcWord_t [`NUM_CORES-1:0] corePc,
	input multicorePkg::instrWord_t memWord,
	output multicorePkg::instrWord_t [`NUM_CORES-1:0] fetchWord
);

	multicorePkg::grantMask_t grantNext;
	multicorePkg::grantMask_t grant;

	// core 1 always fetches, and each further core joins only while every core
	// before it in the chain still agrees with core 1
	always_comb begin
		grantNext = '0;
		grantNext[0] = 1'b1;
		for (int i = 1; i < `NUM_CORES; i++) begin
			grantNext[i] = grantNext[i-1] && (corePc[i] == corePc[0]);
		end
	end

	// registered on the same edge as the memory read so mask and word line up
	always_ff @(posedge c1_endop or negedge rstN) begin
		if (!rstN) begin
			grant <= '0;
		end else begin
			grant <= grantNext;
		end
	end

	genvar g;
	generate
		for (g = 0; g < `NUM_CORES; g++) begin : gateWord
			assign fetchWord[g] = grant[g] ? memWord : '0;
		end
	endgenerate

	// once a fetch has been registered, core 1 is in the mask and the granted
	// cores form one run starting at core 1
	property grantShape;
		@(posedge c1_endop) disable iff (!rstN)
			$past(rstN) |-> grant[0] &&
				((grant & multicorePkg::grantMask_t'(grant + 1'b1)) == '0);
	endproperty

	grantShapeCheck: assert property (grantShape)
		else $error("grant mask is not a contiguous run from core 1");

endmodule

// ==== hdl/coreMonitor.sv ====
`include "multicore_settings.svh"

module coreMonitor (
	input multicorePkg::pcWord_t [`NUM_CORES-1:0] corePc,
	input multicorePkg::coreStatus_t [`NUM_CORES-1:0] coreStatus,
	input logic [1:0] selectCore,
	input multicorePkg::pcWord_t storeCount,
	output multicorePkg::coreStatus_t status,
	output multicorePkg::segDigit_t [`NUM_DIGITS-1:0] segments
);

	localparam int NIBBLE = 4;
	localparam int DISP_WIDTH = `NUM_DIGITS * NIBBLE;

	multicorePkg::pcWord_t selectedPc;
	logic [DISP_WIDTH-1:0] dispValue;

	// standard hex patterns with segment a in bit 0
	function automatic multicorePkg::segDigit_t hexToSeg(input logic [NIBBLE-1:0] nibble);
		multicorePkg::segDigit_t seg;
		case (nibble)
			4'h0: seg = 7'h3F;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5B;
			4'h3: seg = 7'h4F;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6D;
			4'h6: seg = 7'h7D;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h6F;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h7C;
			4'hC: seg = 7'h39;
			4'hD: seg = 7'h5E;
			4'hE: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	// the selected core drives both the status outputs and the upper digits
	assign status = coreStatus[selectCore];
	assign selectedPc = corePc[selectCore];

	// upper four digits show the program counter, lower four the captured count
	assign dispValue = {selectedPc, storeCount};

	always_comb begin
		for (int d = 0; d < `NUM_DIGITS; d++) begin
			segments[d] = hexToSeg(dispValue[d*NIBBLE +: NIBBLE]);
		end
	end

endmodule

// ==== hdl/multiCoreTop.sv ====
`include "multicore_settings.svh"

module multiCoreTop (
	input logic c1_endop,
	input logic rstN,
	input multicorePkg::pcWord_t [`NUM_CORES-1:0] corePc,
	input multicorePkg::coreStatus_t [`NUM_CORES-1:0] coreStatus,
	input logic [1:0] selectCore,
	input logic progDone,
	input logic loadEn,
	input logic [`MEM_ADDR_WIDTH-1:0] loadAddr,
	input multicorePkg::instrWord_t loadData,
	output multicorePkg::instrWord_t [`NUM_CORES-1:0] fetchWord,
	output multicorePkg::coreStatus_t status,
	output multicorePkg::segDigit_t [`NUM_DIGITS-1:0] segments
);

	multicorePkg::pcWord_t countValue;
	multicorePkg::pcWord_t storeCount;
	multicorePkg::instrWord_t memWord;

	cycleCounter cycleCounter_i (
		.c1_endop (c1_endop),
		.rstN (rstN),
		.progDone (progDone),
		.countValue (countValue),
		.storeCount (storeCount)
	);

	// core 1 sets the fetch address for everyone
	instrMemory instrMemory_i (
		.c1_endop (c1_endop),
		.rstN (rstN),
		.readPc (corePc[0]),
		.loadEn (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.progDone (progDone),
		.countValue (countValue),
		.memWord (memWord)
	);

	fetchBroadcast fetchBroadcast_i (
		.c1_endop (c1_endop),
		.rstN (rstN),
		.corePc (corePc),
		.memWord (memWord),
		.fetchWord (fetchWord)
	);

	coreMonitor coreMonitor_i (
		.corePc (corePc),
		.coreStatus (coreStatus),
		.selectCore (selectCore),
		.storeCount (storeCount),
		.status (status),
		.segments (segments)
	);

endmodule

// ==== tests/multiCoreTb.sv ====
`include "multicore_settings.svh"

module multiCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LOAD_DEPTH = 1 << `MEM_ADDR_WIDTH;
	localparam int STATUS_BITS = $bits(multicorePkg::coreStatus_t);
	// a write-back has to be fetched within this many rows of its strobe
	localparam int WRITE_BACK_LIMIT = 8;

	// one row of stimulus together with the grant the priority rule gives it
	typedef struct packed {
		multicorePkg::pcWord_t [`NUM_CORES-1:0] pc;
		multicorePkg::coreStatus_t [`NUM_CORES-1:0] stat;
		logic [1:0] sel;
		logic done;
		logic loadEn;
		logic [`MEM_ADDR_WIDTH-1:0] loadAddr;
		multicorePkg::instrWord_t loadData;
		multicorePkg::grantMask_t expGrant;
	} stimRow_t;

	logic c1_endop = 1'b0;
	logic rstN;
	multicorePkg::pcWord_t [`NUM_CORES-1:0] corePc;
	multicorePkg::coreStatus_t [`NUM_CORES-1:0] coreStatus;
	logic [1:0] selectCore;
	logic progDone;
	logic loadEn;
	logic [`MEM_ADDR_WIDTH-1:0] loadAddr;
	multicorePkg::instrWord_t loadData;
	multicorePkg::instrWord_t [`NUM_CORES-1:0] fetchWord;
	multicorePkg::coreStatus_t status;
	multicorePkg::segDigit_t [`NUM_DIGITS-1:0] segments;

	integer seed;
	stimRow_t stimTable[$];
	stimRow_t curRow;
	stimRow_t idleRow;

	// reference model state
	multicorePkg::instrWord_t shadow [0:LOAD_DEPTH-1];
	multicorePkg::instrWord_t expWord;
	multicorePkg::grantMask_t expGrant;
	multicorePkg::pcWord_t countModel;
	multicorePkg::pcWord_t storeModel;
	int strobeRows[$];
	multicorePkg::pcWord_t strobeCounts[$];

	multiCoreTop multiCoreTop_i (
		.c1_endop (c1_endop),
		.rstN (rstN),
		.corePc (corePc),
		.coreStatus (coreStatus),
		.selectCore (selectCore),
		.progDone (progDone),
		.loadEn (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.fetchWord (fetchWord),
		.status (status),
		.segments (segments)
	);

	always #2 c1_endop = ~c1_endop;

	// standard hex digit patterns with segment a in bit 0
	function automatic multicorePkg::segDigit_t segPattern(input logic [3:0] nibble);
		multicorePkg::segDigit_t seg;
		case (nibble)
			4'h0: seg = 7'h3F;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5B;
			4'h3: seg = 7'h4F;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6D;
			4'h6: seg = 7'h7D;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h6F;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h7C;
			4'hC: seg = 7'h39;
			4'hD: seg = 7'h5E;
			4'hE: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	task automatic failRun();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			failRun();
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout: %s", what);
		failRun();
	endtask

	// reads the captured count back from the four low digits
	task automatic decodeCount(output multicorePkg::pcWord_t value);
		logic [3:0] nib;
		logic found;
		value = '0;
		for (int d = 0; d < 4; d++) begin
			found = 1'b0;
			nib = '0;
			for (int v = 0; v < 16; v++) begin
				if (segments[d] === segPattern(v[3:0])) begin
					nib = v[3:0];
					found = 1'b1;
				end
			end
			if (!found) begin
				$display("digit %0d shows a pattern that is not a hex digit", d);
				failRun();
			end
			value[d*4 +: 4] = nib;
		end
	endtask

	task automatic driveRow(input stimRow_t row);
		curRow = row;
		corePc = row.pc;
		coreStatus = row.stat;
		selectCore = row.sel;
		progDone = row.done;
		loadEn = row.loadEn;
		loadAddr = row.loadAddr;
		loadData = row.loadData;
	endtask

	// what the rising edge does with the row that is driven at that moment
	task automatic updateModel();
		logic [`MEM_ADDR_WIDTH-1:0] addr;
		if (rstN) begin
			addr = curRow.pc[0][`MEM_ADDR_WIDTH-1:0];
			// the read sees the contents from before this edge's write
			expWord = shadow[addr];
			expGrant = curRow.expGrant;
			if (curRow.done) begin
				storeModel = countModel;
				shadow[addr] = multicorePkg::instrWord_t'(countModel);
			end
			if (curRow.loadEn) begin
				shadow[curRow.loadAddr] = curRow.loadData;
			end
			countModel = countModel + 1'b1;
		end
	endtask

	task automatic checkFetch();
		for (int i = 0; i < `NUM_CORES; i++) begin
			checkValue($sformatf("fetchWord[%0d]", i), fetchWord[i],
				expGrant[i] ? expWord : '0);
		end
	endtask

	task automatic checkMonitor();
		multicorePkg::pcWord_t selPc;
		selPc = curRow.pc[curRow.sel];
		checkValue("status", status, curRow.stat[curRow.sel]);
		for (int d = 0; d < 4; d++) begin
			checkValue($sformatf("segments[%0d]", d), segments[d],
				segPattern(storeModel[d*4 +: 4]));
			checkValue($sformatf("segments[%0d]", d + 4), segments[d+4],
				segPattern(selPc[d*4 +: 4]));
		end
	endtask

	// registered outputs are checked before the next row goes out and the monitor after it
	task automatic stepCycle(input stimRow_t nextRow);
		@(posedge c1_endop);
		updateModel();
		#1;
		checkFetch();
		driveRow(nextRow);
		#1;
		checkMonitor();
	endtask

	task automatic addRow(input multicorePkg::pcWord_t pc0, pc1, pc2, pc3,
			input logic [1:0] sel, input logic done, input multicorePkg::grantMask_t grant);
		stimRow_t row;
		logic [63:0] rnd;
		row = idleRow;
		row.pc[0] = pc0;
		row.pc[1] = pc1;
		row.pc[2] = pc2;
		row.pc[3] = pc3;
		row.sel = sel;
		row.done = done;
		row.expGrant = grant;
		for (int i = 0; i < `NUM_CORES; i++) begin
			rnd = {$random(seed), $random(seed)};
			row.stat[i] = rnd[STATUS_BITS-1:0];
		end
		stimTable.push_back(row);
	endtask

	task automatic buildTable();
		// all agree, then core 4, core 3 and core 2 drop out in turn
		addRow(16'h0010, 16'h0010, 16'h0010, 16'h0010, 2'd0, 1'b0, 4'b1111);
		addRow(16'h0011, 16'h0011, 16'h0011, 16'h0099, 2'd1, 1'b0, 4'b0111);
		addRow(16'h0012, 16'h0012, 16'h0088, 16'h0012, 2'd2, 1'b0, 4'b0011);
		addRow(16'h0013, 16'h0077, 16'h0013, 16'h0013, 2'd3, 1'b0, 4'b0001);
		// core 4 agreeing again does not help once core 3 differs
		addRow(16'h0020, 16'h0020, 16'h0021, 16'h0020, 2'd0, 1'b0, 4'b0011);
		addRow(16'h0014, 16'h0014, 16'h0014, 16'h0014, 2'd1, 1'b0, 4'b1111);
		// distinct counters so that each selection shows its own digits
		addRow(16'h1A2B, 16'h3C4D, 16'h5E6F, 16'h9B8F, 2'd0, 1'b0, 4'b0001);
		addRow(16'h1A2B, 16'h3C4D, 16'h5E6F, 16'h9B8F, 2'd1, 1'b0, 4'b0001);
		addRow(16'h1A2B, 16'h3C4D, 16'h5E6F, 16'h9B8F, 2'd2, 1'b0, 4'b0001);
		addRow(16'h1A2B, 16'h3C4D, 16'h5E6F, 16'h9B8F, 2'd3, 1'b0, 4'b0001);
		// first strobe, then the unchanged counters fetch the write-back
		addRow(16'h0040, 16'h0040, 16'h0040, 16'h0040, 2'd1, 1'b1, 4'b1111);
		addRow(16'h0040, 16'h0040, 16'h0040, 16'h0040, 2'd1, 1'b0, 4'b1111);
		addRow(16'h0041, 16'h0041, 16'h0041, 16'h0041, 2'd2, 1'b0, 4'b1111);
		addRow(16'h0042, 16'h0042, 16'h0042, 16'h0043, 2'd3, 1'b0, 4'b0111);
		// second strobe four rows after the first
		addRow(16'h0050, 16'h0050, 16'h0050, 16'h0050, 2'd0, 1'b1, 4'b1111);
		addRow(16'h0050, 16'h0050, 16'h0050, 16'h0050, 2'd0, 1'b0, 4'b1111);
		addRow(16'h0060, 16'h0060, 16'h0061, 16'h0060, 2'd1, 1'b0, 4'b0011);
	endtask

	initial begin
		stimRow_t row;
		logic [31:0] rndWord;
		multicorePkg::pcWord_t captured;
		multicorePkg::pcWord_t pendingCount;
		logic [`MEM_ADDR_WIDTH-1:0] pendingAddr;
		logic pending;
		int waitRows;
		int diff;

		seed = 59;
		idleRow = '0;
		idleRow.expGrant = '1;
		rstN = 1'b0;
		driveRow(idleRow);
		expWord = '0;
		expGrant = '0;
		countModel = '0;
		storeModel = '0;
		pending = 1'b0;
		pendingAddr = '0;
		pendingCount = '0;
		waitRows = 0;

		// nothing has been fetched while reset is held or just after it
		for (int i = 0; i < 4; i++) begin
			@(posedge c1_endop);
			#1;
			checkFetch();
			checkMonitor();
		end
		rstN = 1'b1;
		#1;
		checkFetch();
		checkMonitor();

		for (int a = 0; a < LOAD_DEPTH; a++) begin
			row = idleRow;
			rndWord = $random(seed);
			row.loadEn = 1'b1;
			row.loadAddr = a[`MEM_ADDR_WIDTH-1:0];
			row.loadData = rndWord[`INSTR_WIDTH-1:0];
			stepCycle(row);
		end

		buildTable();
		for (int r = 0; r <= stimTable.size(); r++) begin
			if (r < stimTable.size()) begin
				row = stimTable[r];
			end else begin
				row = idleRow;
			end
			stepCycle(row);
			// the previous row's results are visible now
			if (r > 0) begin
				if (stimTable[r-1].done) begin
					decodeCount(captured);
					strobeRows.push_back(r - 1);
					strobeCounts.push_back(captured);
					pending = 1'b1;
					pendingAddr = stimTable[r-1].pc[0][`MEM_ADDR_WIDTH-1:0];
					pendingCount = captured;
					waitRows = 0;
				end else if (pending) begin
					if (stimTable[r-1].pc[0][`MEM_ADDR_WIDTH-1:0] == pendingAddr) begin
						checkValue("write-back word", fetchWord[0],
							multicorePkg::instrWord_t'(pendingCount));
						pending = 1'b0;
					end else begin
						waitRows++;
						if (waitRows > WRITE_BACK_LIMIT) begin
							reportTimeout("the write-back word was not fetched after its strobe");
						end
					end
				end
			end
		end
		if (pending) begin
			reportTimeout("the table ended before the write-back word was fetched");
		end

		checkValue("second count above first", strobeCounts[1] > strobeCounts[0], 1'b1);
		diff = strobeRows[1] - strobeRows[0];
		checkValue("count difference", strobeCounts[1] - strobeCounts[0], diff);

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/multicorePkg.sv
hdl/cycleCounter.sv
hdl/instrMemory.sv
hdl/fetchBroadcast.sv
hdl/coreMonitor.sv
hdl/multiCoreTop.sv
tests/multiCoreTb.sv

// ==== Bender.yml ====
package:
  name: multicore

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/multicorePkg.sv
      - hdl/cycleCounter.sv
      - hdl/instrMemory.sv
      - hdl/fetchBroadcast.sv
      - hdl/coreMonitor.sv
      - hdl/multiCoreTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tests/multiCoreTb.sv
